//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

  localparam int flagW = 3; // Z, V and N

  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    XOR = 4'd2,
    LW  = 4'd8,
    SW  = 4'd9,
    LLB = 4'd10,
    B   = 4'd12,
    PCS = 4'd14,
    HLT = 4'd15
  } opcodeT;

  // Spare encoding, used for bubbles and squashed fetches
  localparam opcodeT nopOp = opcodeT'(4'd3);

  typedef enum logic [2:0] {
    NE     = 3'd0,
    EQ     = 3'd1,
    GT     = 3'd2, // Z and N both clear
    LT     = 3'd3, // N set
    ALWAYS = 3'd7
  } condT;

  // Write-back source, selHlt marks the HLT slot
  typedef enum logic [1:0] {
    selAlu = 2'd0,
    selMem = 2'd1,
    selPc  = 2'd2,
    selHlt = 2'd3
  } wbSelT;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flagsT;

  typedef struct packed {
    opcodeT     op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } rFmtT;

  typedef struct packed {
    opcodeT            op;
    logic [3:0]        rd; // Data register for SW
    logic [3:0]        rs; // Base register
    logic signed [3:0] off; // Word offset
  } mFmtT;

  typedef struct packed {
    opcodeT     op;
    logic [3:0] rd;
    logic [7:0] imm;
  } iFmtT;

  typedef struct packed {
    opcodeT            op;
    condT              cond;
    logic signed [8:0] off; // Word offset from PC+2
  } bFmtT;

  typedef union packed {
    rFmtT rFmt;
    mFmtT mFmt;
    iFmtT iFmt;
    bFmtT bFmt;
  } instrT;

endpackage

`default_nettype wire

//--- fetch.sv
`default_nettype none
`timescale 1ns/1ps

module fetch #(
  parameter int imemDepth = 256
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic        progWe,
  input  logic [15:0] progAddr, // Byte address, like pc
  input  logic [15:0] progData,
  input  logic        stall,
  input  logic        flush,
  input  logic        halted,
  input  logic        branchTaken,
  input  logic [15:0] branchTarget,
  output logic [15:0] pc,
  output logic [15:0] ifIdPc,
  output logic [15:0] ifIdPcNext,
  output logic [15:0] ifIdInstr
);
  import cpuPkg::*;

  localparam int addrW = $clog2(imemDepth);

  logic [15:0] imem [imemDepth]; // Instruction memory, loaded in reset
  logic [15:0] pcPlus2;
  logic [15:0] instrWord;
  logic        haltSeen; // Sticky once HLT has left decode
  logic        frozen;

  always_ff @(posedge clk) begin
    if (!rstN && progWe) begin
      imem[progAddr[addrW:1]] <= progData; // Program port only while in reset
    end
  end

  assign pcPlus2   = pc + 16'd2;
  assign instrWord = imem[pc[addrW:1]]; // Combinational read
  assign frozen    = halted || haltSeen;

  //////////////////////////////
  // PC
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc       <= '0;
      haltSeen <= 1'b0;
    end else begin
      if (halted) begin
        haltSeen <= 1'b1;
      end
      if (!(stall || frozen)) begin
        pc <= branchTaken ? branchTarget : pcPlus2; // Stall wins over redirect
      end
    end
  end

  //////////////////////////////
  // IF/ID register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN || flush || frozen) begin
      ifIdInstr <= {nopOp, 12'h000}; // Squash the slot behind a branch or HLT
    end else if (!stall) begin
      ifIdInstr <= instrWord;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ifIdPc <= pc;
    end
  end

  assign ifIdPcNext = ifIdPc + 16'd2; // Return value for PCS, base for B

endmodule

`default_nettype wire

//--- decode.sv
`default_nettype none
`timescale 1ns/1ps

module decode (
  input  logic                clk,
  input  logic                rstN,
  input  logic [15:0]         ifIdPcNext,
  input  cpuPkg::instrT       ifIdInstr,
  input  cpuPkg::flagsT       flags,
  input  logic                stall,
  input  logic [3:0]          memWbRd,
  input  logic                memWbRegWrite,
  input  logic [15:0]         memWbData,
  output cpuPkg::opcodeT      idExOp,
  output logic [3:0]          idExRd,
  output logic [15:0]         idExA,
  output logic [15:0]         idExB,
  output logic [15:0]         idExStoreData,
  output logic                idExRegWrite,
  output logic                idExMemRead,
  output logic                idExMemWrite,
  output logic [15:0]         idExPcNext,
  output cpuPkg::wbSelT       idExSel,
  output logic                branchTaken,
  output logic [15:0]         branchTarget,
  output logic [3:0]          idRs,
  output logic [3:0]          idRt,
  output logic                idUsesFlags,
  output logic                idIsHlt
);
  import cpuPkg::*;

  logic [15:0] regFile [16]; // r0 is never written
  opcodeT      op;
  logic        isAlu;
  logic [15:0] rsVal;
  logic [15:0] rtVal;
  logic [15:0] opB;
  logic        condMet;
  logic        regWrite;
  wbSelT       sel;

  assign op    = ifIdInstr.rFmt.op; // Opcode sits in the same place in all formats
  assign isAlu = (op == ADD) || (op == SUB) || (op == XOR);

  // Source registers, zero when a format reads none
  always_comb begin
    idRs = 4'd0;
    idRt = 4'd0;
    case (op)
      ADD, SUB, XOR: begin
        idRs = ifIdInstr.rFmt.rs;
        idRt = ifIdInstr.rFmt.rt;
      end
      LW: idRs = ifIdInstr.mFmt.rs;
      SW: begin
        idRs = ifIdInstr.mFmt.rs;
        idRt = ifIdInstr.mFmt.rd; // Store data comes from rd
      end
      default: ;
    endcase
  end

  //////////////////////////////
  // Register file
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (memWbRegWrite && (memWbRd != 4'd0)) begin
      regFile[memWbRd] <= memWbData;
    end
  end

  // Write-through, the WB value is seen in the same cycle
  assign rsVal = (idRs == 4'd0) ? 16'h0000 :
                 (memWbRegWrite && (memWbRd == idRs)) ? memWbData : regFile[idRs];
  assign rtVal = (idRt == 4'd0) ? 16'h0000 :
                 (memWbRegWrite && (memWbRd == idRt)) ? memWbData : regFile[idRt];

  //////////////////////////////
  // Branch resolution
  //////////////////////////////
  always_comb begin
    case (ifIdInstr.bFmt.cond)
      NE:      condMet = ~flags.z;
      EQ:      condMet = flags.z;
      GT:      condMet = ~flags.z & ~flags.n;
      LT:      condMet = flags.n;
      ALWAYS:  condMet = 1'b1;
      default: condMet = 1'b0; // Reserved codes never branch
    endcase
  end

  assign branchTaken  = (op == B) && condMet;
  assign branchTarget = ifIdPcNext +
                        {{6{ifIdInstr.bFmt.off[8]}}, ifIdInstr.bFmt.off, 1'b0};
  assign idUsesFlags  = (op == B);
  assign idIsHlt      = (op == HLT);

  // Operand B by format
  always_comb begin
    case (op)
      LW, SW:  opB = {{11{ifIdInstr.mFmt.off[3]}}, ifIdInstr.mFmt.off, 1'b0};
      LLB:     opB = {{8{ifIdInstr.iFmt.imm[7]}}, ifIdInstr.iFmt.imm};
      default: opB = rtVal;
    endcase
  end

  assign regWrite = isAlu || (op == LW) || (op == LLB) || (op == PCS);

  always_comb begin
    case (op)
      LW:      sel = selMem;
      PCS:     sel = selPc;
      HLT:     sel = selHlt;
      default: sel = selAlu;
    endcase
  end

  //////////////////////////////
  // ID/EX register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN || stall) begin
      idExOp       <= nopOp; // Bubble
      idExRegWrite <= 1'b0;
      idExMemRead  <= 1'b0;
      idExMemWrite <= 1'b0;
      idExSel      <= selAlu;
    end else begin
      idExOp       <= op;
      idExRegWrite <= regWrite;
      idExMemRead  <= (op == LW);
      idExMemWrite <= (op == SW);
      idExSel      <= sel;
    end
  end

  always_ff @(posedge clk) begin
    idExRd        <= ifIdInstr.rFmt.rd;
    idExA         <= rsVal;
    idExB         <= opB;
    idExStoreData <= rtVal; // idRt is rd for SW
    idExPcNext    <= ifIdPcNext;
  end

endmodule

`default_nettype wire

//--- hazardUnit.sv
`default_nettype none
`timescale 1ns/1ps

module hazardUnit (
  input  logic           [3:0] idRs,
  input  logic           [3:0] idRt,
  input  logic                 idUsesFlags,
  input  logic                 idIsHlt,
  input  logic           [3:0] idExRd,
  input  logic                 idExRegWrite,
  input  cpuPkg::opcodeT       idExOp,
  input  logic           [3:0] exMemRd,
  input  logic                 exMemRegWrite,
  input  logic                 branchTaken,
  output logic                 stall,
  output logic                 flush,
  output logic                 halted
);
  import cpuPkg::*;

  logic rsHit;
  logic rtHit;
  logic flagHit;

  // No forwarding, so wait until the writer is in WB
  assign rsHit = (idRs != 4'd0) &&
                 ((idExRegWrite && (idExRd == idRs)) ||
                  (exMemRegWrite && (exMemRd == idRs)));
  assign rtHit = (idRt != 4'd0) &&
                 ((idExRegWrite && (idExRd == idRt)) ||
                  (exMemRegWrite && (exMemRd == idRt)));

  // Flag register updates at the end of EX, one cycle is enough
  assign flagHit = idUsesFlags &&
                   ((idExOp == ADD) || (idExOp == SUB) || (idExOp == XOR));

  assign stall  = rsHit || rtHit || flagHit;
  assign flush  = branchTaken && !stall; // Drop the slot fetched behind the branch
  assign halted = idIsHlt;

endmodule

`default_nettype wire

//--- execute.sv
`default_nettype none
`timescale 1ns/1ps

module execute (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::opcodeT idExOp,
  input  logic [3:0]     idExRd,
  input  logic [15:0]    idExA,
  input  logic [15:0]    idExB,
  input  logic [15:0]    idExStoreData,
  input  logic           idExRegWrite,
  input  logic           idExMemRead,
  input  logic           idExMemWrite,
  input  logic [15:0]    idExPcNext,
  input  cpuPkg::wbSelT  idExSel,
  output cpuPkg::flagsT  flags,
  output logic [15:0]    exMemResult,
  output logic [15:0]    exMemStoreData,
  output logic [3:0]     exMemRd,
  output logic           exMemRegWrite,
  output logic           exMemMemRead,
  output logic           exMemMemWrite,
  output cpuPkg::wbSelT  exMemSel,
  output logic [15:0]    exMemPcNext
);
  import cpuPkg::*;

  logic [15:0]      sum;
  logic [15:0]      diff;
  logic [15:0]      result;
  flagsT            flagsNext;
  logic [flagW-1:0] flagEn; // Bit order z, v, n

  assign sum  = idExA + idExB;
  assign diff = idExA - idExB;

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    flagEn = '0;
    case (idExOp)
      ADD: begin
        result = sum;
        flagEn = 3'b111;
      end
      SUB: begin
        result = diff;
        flagEn = 3'b111;
      end
      XOR: begin
        result = idExA ^ idExB;
        flagEn = 3'b100; // Z only
      end
      LW, SW:  result = sum; // Address add
      LLB:     result = idExB;
      default: result = 16'h0000;
    endcase
  end

  assign flagsNext.z = (result == 16'h0000);
  assign flagsNext.n = result[15];
  assign flagsNext.v = (idExOp == SUB) ?
                       ((idExA[15] != idExB[15]) && (diff[15] != idExA[15])) :
                       ((idExA[15] == idExB[15]) && (sum[15] != idExA[15]));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else begin
      flags <= (flagsNext & flagEn) | (flags & ~flagEn); // Keep the untouched flags
    end
  end

  //////////////////////////////
  // EX/MEM register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMemRegWrite <= 1'b0;
      exMemMemRead  <= 1'b0;
      exMemMemWrite <= 1'b0;
      exMemSel      <= selAlu;
    end else begin
      exMemRegWrite <= idExRegWrite;
      exMemMemRead  <= idExMemRead;
      exMemMemWrite <= idExMemWrite;
      exMemSel      <= idExSel;
    end
  end

  always_ff @(posedge clk) begin
    exMemResult    <= result;
    exMemStoreData <= idExStoreData;
    exMemRd        <= idExRd;
    exMemPcNext    <= idExPcNext;
  end

endmodule

`default_nettype wire

//--- memStage.sv
`default_nettype none
`timescale 1ns/1ps

module memStage #(
  parameter int dmemDepth = 256
) (
  input  logic          clk,
  input  logic          rstN,
  input  logic [15:0]   exMemResult,
  input  logic [15:0]   exMemStoreData,
  input  logic [3:0]    exMemRd,
  input  logic          exMemRegWrite,
  input  logic          exMemMemRead,
  input  logic          exMemMemWrite,
  input  cpuPkg::wbSelT exMemSel,
  input  logic [15:0]   exMemPcNext,
  output logic [15:0]   memWbData,
  output logic [3:0]    memWbRd,
  output logic          memWbRegWrite,
  output logic          memWbHlt
);
  import cpuPkg::*;

  localparam int addrW = $clog2(dmemDepth);

  logic [15:0]      dmem [dmemDepth];
  logic [addrW-1:0] idx;
  logic [15:0]      readData;
  logic [15:0]      wbValue;

  assign idx = exMemResult[addrW:1]; // Word index from byte address

  always_ff @(posedge clk) begin
    if (exMemMemWrite) begin
      dmem[idx] <= exMemStoreData;
    end
  end

  assign readData = exMemMemRead ? dmem[idx] : 16'h0000;

  always_comb begin
    case (exMemSel)
      selMem:  wbValue = readData;
      selPc:   wbValue = exMemPcNext; // PCS
      default: wbValue = exMemResult;
    endcase
  end

  //////////////////////////////
  // MEM/WB register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      memWbRegWrite <= 1'b0;
      memWbHlt      <= 1'b0;
    end else begin
      memWbRegWrite <= exMemRegWrite;
      memWbHlt      <= memWbHlt || (exMemSel == selHlt); // Held until reset
    end
  end

  always_ff @(posedge clk) begin
    memWbData <= wbValue;
    memWbRd   <= exMemRd;
  end

endmodule

`default_nettype wire

//--- cpu.sv
`default_nettype none
`timescale 1ns/1ps

module cpu #(
  parameter int imemDepth = 256,
  parameter int dmemDepth = 256
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic        progWe,
  input  logic [15:0] progAddr,
  input  logic [15:0] progData,
  output logic        hlt,
  output logic [15:0] pc,
  output logic        wbValid,
  output logic [3:0]  wbReg,
  output logic [15:0] wbData
);
  import cpuPkg::*;

  // Hazard controls
  logic        stall;
  logic        flush;
  logic        halted;

  // IF/ID
  logic [15:0] ifIdPc; // Tap for the bound checker
  logic [15:0] ifIdPcNext;
  logic [15:0] ifIdInstr;

  // Decode side
  logic        branchTaken;
  logic [15:0] branchTarget;
  logic [3:0]  idRs;
  logic [3:0]  idRt;
  logic        idUsesFlags;
  logic        idIsHlt;

  // ID/EX
  opcodeT      idExOp;
  logic [3:0]  idExRd;
  logic [15:0] idExA;
  logic [15:0] idExB;
  logic [15:0] idExStoreData;
  logic        idExRegWrite;
  logic        idExMemRead;
  logic        idExMemWrite;
  logic [15:0] idExPcNext;
  wbSelT       idExSel;

  // EX/MEM
  flagsT       flags;
  logic [15:0] exMemResult;
  logic [15:0] exMemStoreData;
  logic [3:0]  exMemRd;
  logic        exMemRegWrite;
  logic        exMemMemRead;
  logic        exMemMemWrite;
  wbSelT       exMemSel;
  logic [15:0] exMemPcNext;

  // MEM/WB
  logic [15:0] memWbData;
  logic [3:0]  memWbRd;
  logic        memWbRegWrite;
  logic        memWbHlt;

  //////////////////////////////
  // Stages
  //////////////////////////////
  fetch #(.imemDepth(imemDepth)) iFetch (
    .clk(clk), .rstN(rstN),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .stall(stall), .flush(flush), .halted(halted),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .pc(pc), .ifIdPc(ifIdPc), .ifIdPcNext(ifIdPcNext), .ifIdInstr(ifIdInstr)
  );

  decode iDecode (
    .clk(clk), .rstN(rstN),
    .ifIdPcNext(ifIdPcNext), .ifIdInstr(ifIdInstr), .flags(flags), .stall(stall),
    .memWbRd(memWbRd), .memWbRegWrite(memWbRegWrite), .memWbData(memWbData),
    .idExOp(idExOp), .idExRd(idExRd), .idExA(idExA), .idExB(idExB),
    .idExStoreData(idExStoreData), .idExRegWrite(idExRegWrite),
    .idExMemRead(idExMemRead), .idExMemWrite(idExMemWrite),
    .idExPcNext(idExPcNext), .idExSel(idExSel),
    .branchTaken(branchTaken), .branchTarget(branchTarget),
    .idRs(idRs), .idRt(idRt), .idUsesFlags(idUsesFlags), .idIsHlt(idIsHlt)
  );

  hazardUnit iHazard (
    .idRs(idRs), .idRt(idRt), .idUsesFlags(idUsesFlags), .idIsHlt(idIsHlt),
    .idExRd(idExRd), .idExRegWrite(idExRegWrite), .idExOp(idExOp),
    .exMemRd(exMemRd), .exMemRegWrite(exMemRegWrite), .branchTaken(branchTaken),
    .stall(stall), .flush(flush), .halted(halted)
  );

  execute iExecute (
    .clk(clk), .rstN(rstN),
    .idExOp(idExOp), .idExRd(idExRd), .idExA(idExA), .idExB(idExB),
    .idExStoreData(idExStoreData), .idExRegWrite(idExRegWrite),
    .idExMemRead(idExMemRead), .idExMemWrite(idExMemWrite),
    .idExPcNext(idExPcNext), .idExSel(idExSel), .flags(flags),
    .exMemResult(exMemResult), .exMemStoreData(exMemStoreData), .exMemRd(exMemRd),
    .exMemRegWrite(exMemRegWrite), .exMemMemRead(exMemMemRead),
    .exMemMemWrite(exMemMemWrite), .exMemSel(exMemSel), .exMemPcNext(exMemPcNext)
  );

  memStage #(.dmemDepth(dmemDepth)) iMem (
    .clk(clk), .rstN(rstN),
    .exMemResult(exMemResult), .exMemStoreData(exMemStoreData), .exMemRd(exMemRd),
    .exMemRegWrite(exMemRegWrite), .exMemMemRead(exMemMemRead),
    .exMemMemWrite(exMemMemWrite), .exMemSel(exMemSel), .exMemPcNext(exMemPcNext),
    .memWbData(memWbData), .memWbRd(memWbRd),
    .memWbRegWrite(memWbRegWrite), .memWbHlt(memWbHlt)
  );

  // Retire trace
  assign wbValid = memWbRegWrite;
  assign wbReg   = memWbRd;
  assign wbData  = memWbData;
  assign hlt     = memWbHlt; // HLT has reached WB

endmodule

`default_nettype wire

//--- cpu_chk.sv
`default_nettype none
`timescale 1ns/1ps

module cpuChk (
  input logic        clk,
  input logic        rstN,
  input logic        stall,
  input logic [15:0] pc,
  input logic [15:0] ifIdPc,
  input logic [15:0] ifIdInstr,
  input logic        hlt,
  input logic        wbValid
);

  // A stalled slot stays in IF/ID and is never flushed
  ifIdHeldOnStall: assert property (@(posedge clk) disable iff (!rstN)
    stall |=> ($stable(ifIdInstr) && $stable(ifIdPc)))
    else $error("IF/ID changed during a stall");

  pcHeldOnStall: assert property (@(posedge clk) disable iff (!rstN)
    stall |=> (pc == $past(pc)))
    else $error("pc moved during a stall");

  // Sticky until the next reset
  hltSticky: assert property (@(posedge clk) disable iff (!rstN) hlt |=> hlt)
    else $error("hlt fell while out of reset");

  noRetireAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !wbValid)
    else $error("wbValid high in the first cycle after reset");

endmodule

bind cpu cpuChk uChk (
  .clk(clk),
  .rstN(rstN),
  .stall(stall),
  .pc(pc),
  .ifIdPc(ifIdPc),
  .ifIdInstr(ifIdInstr),
  .hlt(hlt),
  .wbValid(wbValid)
);

`default_nettype wire

//--- cpu_tb.sv
`default_nettype none
`timescale 1ns/1ps

module cpuTb;
  import cpuPkg::*;

  localparam int nRows         = 26;
  localparam int timeoutCycles = 8 * nRows + 50;
  localparam logic [31:0] seed = 32'd43473;

  logic        clk;
  logic        rstN;
  logic        progWe;
  logic [15:0] progAddr;
  logic [15:0] progData;
  logic        hlt;
  logic [15:0] pc;
  logic        wbValid;
  logic [3:0]  wbReg;
  logic [15:0] wbData;

  // Program rows with LCG-filled LLB immediates
  logic [15:0] progTbl [nRows] = '{
    16'hA100, // 0  LLB r1
    16'hA200, // 2  LLB r2
    16'hA300, // 4  LLB r3
    16'h0412, // 6  ADD r4, r1, r2
    16'h1543, // 8  SUB r5, r4, r3
    16'h2651, // 10 XOR r6, r5, r1
    16'h0766, // 12 ADD r7, r6, r6
    16'h9702, // 14 SW r7, 4(r0)
    16'h8102, // 16 LW r1, 4(r0)
    16'h0211, // 18 ADD r2, r1, r1 (load-use)
    16'h1322, // 20 SUB r3, r2, r2 (sets Z)
    16'hC201, // 22 B EQ +1
    16'hA400, // 24 LLB r4 (skipped)
    16'hC001, // 26 B NE +1 (not taken)
    16'hE500, // 28 PCS r5
    16'h0612, // 30 ADD r6, r1, r2
    16'hC401, // 32 B GT +1
    16'hA700, // 34 LLB r7
    16'hC601, // 36 B LT +1
    16'h2336, // 38 XOR r3, r3, r6
    16'hCE01, // 40 B ALWAYS +1
    16'hA100, // 42 LLB r1 (skipped)
    16'h1401, // 44 SUB r4, r0, r1
    16'hC601, // 46 B LT +1
    16'hE200, // 48 PCS r2
    16'hF000  // 50 HLT
  };

  logic [15:0] prog [nRows];
  logic [19:0] expQ [$]; // {reg, value} in program order
  logic [15:0] finalPc;
  logic [31:0] lcgState;
  int          errors;
  int          cycles;
  int          retired;

  cpu #(.imemDepth(256), .dmemDepth(256)) UUT (
    .clk(clk), .rstN(rstN),
    .progWe(progWe), .progAddr(progAddr), .progData(progData),
    .hlt(hlt), .pc(pc), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk; // 8 ns period

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  //////////////////////////////
  // ISA reference model
  //////////////////////////////
  task automatic buildExpected();
    logic [15:0] regs [16];
    logic [15:0] dmemModel [256];
    logic [15:0] mpc;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] addr;
    logic        z;
    logic        v;
    logic        n;
    logic        taken;
    logic        wr;
    logic        done;
    int          idx;
    int          steps;
    for (int r = 0; r < 16; r++) regs[r] = 16'h0000;
    mpc     = 16'h0000;
    finalPc = 16'hFFFF; // Stays if HLT is never reached
    z       = 1'b0;
    v       = 1'b0;
    n       = 1'b0;
    done    = 1'b0;
    steps   = 0;
    while (!done && steps < 4 * nRows) begin
      idx = int'(mpc[15:1]);
      if (idx >= nRows) begin
        done = 1'b1; // Ran off the program
      end else begin
        w   = prog[idx];
        a   = regs[w[7:4]];
        b   = regs[w[3:0]];
        wr  = 1'b0;
        res = 16'h0000;
        addr = regs[w[7:4]] + {{11{w[3]}}, w[3:0], 1'b0}; // Base plus word offset
        case (w[15:12])
          ADD: begin
            res = a + b;
            z   = (res == 16'h0000);
            n   = res[15];
            v   = (a[15] == b[15]) && (res[15] != a[15]); // Same signs in, other sign out
            wr  = 1'b1;
          end
          SUB: begin
            res = a - b;
            z   = (res == 16'h0000);
            n   = res[15];
            v   = (a[15] != b[15]) && (res[15] != a[15]);
            wr  = 1'b1;
          end
          XOR: begin
            res = a ^ b;
            z   = (res == 16'h0000); // Only Z moves
            wr  = 1'b1;
          end
          LW: begin
            res = dmemModel[addr[8:1]];
            wr  = 1'b1;
          end
          SW:  dmemModel[addr[8:1]] = regs[w[11:8]];
          LLB: begin
            res = {{8{w[7]}}, w[7:0]};
            wr  = 1'b1;
          end
          PCS: begin
            res = mpc + 16'd2;
            wr  = 1'b1;
          end
          HLT: begin
            finalPc = mpc + 16'd2; // Fetch behind HLT already stepped the PC
            done    = 1'b1;
          end
          default: ;
        endcase
        taken = 1'b0;
        if (w[15:12] == B) begin
          case (w[11:9])
            3'd0:    taken = !z;
            3'd1:    taken = z;
            3'd2:    taken = !z && !n;
            3'd3:    taken = n;
            3'd7:    taken = 1'b1;
            default: taken = 1'b0;
          endcase
        end
        if (wr) begin
          expQ.push_back({w[11:8], res});
          if (w[11:8] != 4'd0) regs[w[11:8]] = res;
        end
        mpc = taken ? mpc + 16'd2 + {{6{w[8]}}, w[8:0], 1'b0} : mpc + 16'd2;
      end
      steps++;
    end
  endtask

  task automatic checkRetire();
    logic [19:0] e;
    retired++;
    if (expQ.size() == 0) begin
      $display("A write to r%0d retired with nothing left to retire", wbReg);
      errors++;
    end else begin
      e = expQ.pop_front();
      if (wbReg !== e[19:16]) begin
        $display("Fail wbReg: got %h, expected %h", wbReg, e[19:16]);
        errors++;
      end
      if (wbData !== e[15:0]) begin
        $display("Fail wbData: got %h, expected %h", wbData, e[15:0]);
        errors++;
      end
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    errors   = 0;
    cycles   = 0;
    retired  = 0;
    rstN     = 1'b0;
    progWe   = 1'b0;
    progAddr = 16'h0000;
    progData = 16'h0000;
    lcgState = seed;
    for (int i = 0; i < nRows; i++) begin
      prog[i] = progTbl[i];
      if (progTbl[i][15:12] == LLB) begin
        lcgState   = lcgNext(lcgState);
        prog[i][7:0] = lcgState[23:16]; // Upper bits spread better
      end
    end
    buildExpected();
    for (int i = 0; i < nRows; i++) begin
      @(negedge clk);
      progWe   = 1'b1;
      progAddr = 16'(2 * i);
      progData = prog[i];
    end
    @(negedge clk);
    progWe = 1'b0;
    repeat (3) @(negedge clk); // Reset held 3 more cycles
    if (pc !== 16'h0000) begin
      $display("Fail pc: got %h, expected %h", pc, 16'h0000);
      errors++;
    end
    if (hlt !== 1'b0) begin
      $display("Fail hlt: got %h, expected %h", hlt, 1'b0);
      errors++;
    end
    if (wbValid !== 1'b0) begin
      $display("Fail wbValid: got %h, expected %h", wbValid, 1'b0);
      errors++;
    end
    rstN = 1'b1;
    while (hlt !== 1'b1 && cycles < timeoutCycles) begin
      @(negedge clk);
      cycles++;
      if (wbValid) checkRetire();
    end
    if (hlt !== 1'b1) begin
      $display("Timeout, hlt did not rise within %0d cycles", timeoutCycles);
      errors++;
    end else begin
      if (expQ.size() != 0) begin
        $display("Halted with %0d expected retirements still missing", expQ.size());
        errors++;
      end
      if (pc !== finalPc) begin
        $display("Fail pc: got %h, expected %h", pc, finalPc);
        errors++;
      end
      repeat (6) begin
        @(negedge clk);
        if (wbValid !== 1'b0) begin
          $display("A register write retired after the halt");
          errors++;
        end
      end
    end
    $display("%0d retirements checked, %0d errors", retired, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
cpuPkg.sv
fetch.sv
decode.sv
hazardUnit.sv
execute.sv
memStage.sv
cpu.sv
cpu_chk.sv
cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module cpuTb -o cpuSim

status=0
./obj_dir/cpuSim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
grep -qx "TEST RESULT: PASS" sim.log
